// ==== switchPkg.sv ====
/*
 * Shared widths, slot geometry and word types for the two-port packet switch.
 * Every RTL block and the testbench import this package.
 */
`default_nettype none

package switchPkg;

    localparam int dataWidth = 32;
    localparam int slotCount = 4;

    // Raise this to allow longer packets; index widths follow
    localparam int maxPayload = 15;
    localparam int wordsPerSlot = maxPayload + 1;

    localparam int slotIdxW = $clog2(slotCount);
    localparam int wordIdxW = $clog2(wordsPerSlot);
    localparam int lenW = 8;

    // Destination id routed to PortA, everything else goes to PortB
    localparam logic [7:0] portAId = 8'd0;

    typedef struct packed {
        logic [7:0] dest;
        logic [lenW-1:0] length;
        logic [15:0] tag;
    } headerFields;

    // Header view and raw view of the same stream word
    typedef union packed {
        headerFields hdr;
        logic [dataWidth-1:0] raw;
    } pktWord;

    typedef enum logic [1:0] {
        idle,
        header,
        payload,
        done
    } senderState;

endpackage

`default_nettype wire

// ==== pktClassifier.sv ====
/*
 * Input side of the switch. Picks the destination port from the header,
 * numbers the words of each packet for the port buffer and issues the
 * commit with the length-corrected header on the last word.
 */
`timescale 1ns/1ps
`default_nettype none

module pktClassifier (
    input  logic clk,
    input  logic nrst,
    input  logic sop,
    input  logic eop,
    input  logic inValid,
    input  switchPkg::pktWord portIn,
    output logic wrEnA,
    output logic wrEnB,
    output logic commitA,
    output logic commitB,
    output logic [switchPkg::wordIdxW-1:0] wrWord,
    output switchPkg::pktWord wrData,
    output switchPkg::pktWord hdrData
);
    import switchPkg::*;

    // Low while waiting for a header, high inside a packet
    logic inPkt;
    logic selA;
    logic [wordIdxW-1:0] wordCnt;
    pktWord hdrHeld;

    logic destIsA;
    logic startHdr;
    logic wrActive;
    logic selNow;
    logic lastWord;

    assign destIsA = (portIn.hdr.dest == portAId);
    assign startHdr = !inPkt && inValid && sop;
    assign wrActive = startHdr || (inPkt && inValid);

    // Header decides directly, later words use the latched choice
    assign selNow = inPkt ? selA : destIsA;
    assign lastWord = wrActive && eop;

    assign wrEnA = wrActive && selNow;
    assign wrEnB = wrActive && !selNow;
    assign commitA = lastWord && selNow;
    assign commitB = lastWord && !selNow;

    assign wrWord = inPkt ? wordCnt : '0;
    assign wrData = portIn;

    // Index of the eop word equals the payload count
    always_comb begin
        hdrData = inPkt ? hdrHeld : portIn;
        hdrData.hdr.length = inPkt ? {{(lenW - wordIdxW){1'b0}}, wordCnt} : '0;
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            inPkt <= 1'b0;
            selA <= 1'b0;
            wordCnt <= '0;
        end else if (startHdr) begin
            selA <= destIsA;
            wordCnt <= wordIdxW'(1);
            // Header-only packets finish on the same word
            inPkt <= !eop;
        end else if (inPkt && inValid) begin
            if (eop) begin
                inPkt <= 1'b0;
            end else begin
                wordCnt <= wordCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (startHdr) begin
            hdrHeld <= portIn;
        end
    end

endmodule

`default_nettype wire

// ==== pktStore.sv ====
/*
 * Packet buffer for one output port. Holds up to four whole packets in
 * arrival order and hands the oldest one to the port sender.
 */
`timescale 1ns/1ps
`default_nettype none

module pktStore (
    input  logic clk,
    input  logic nrst,
    input  logic wrEn,
    input  logic [switchPkg::wordIdxW-1:0] wrWord,
    input  switchPkg::pktWord wrData,
    input  logic commit,
    input  switchPkg::pktWord hdrData,
    input  logic [switchPkg::wordIdxW-1:0] rdWord,
    input  logic releasePkt,
    output switchPkg::pktWord rdData,
    output logic pktAvail,
    output logic ready
);
    import switchPkg::*;

    pktWord mem [slotCount][wordsPerSlot];

    logic [slotIdxW-1:0] wrSlot;
    logic [slotIdxW-1:0] rdSlot;
    logic [slotIdxW:0] occupancy;
    logic [slotIdxW:0] occNext;

    always_comb begin
        case ({commit, releasePkt})
            2'b10: occNext = occupancy + 1'b1;
            2'b01: occNext = occupancy - 1'b1;
            default: occNext = occupancy;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            wrSlot <= '0;
            rdSlot <= '0;
            occupancy <= '0;
            ready <= 1'b0;
        end else begin
            if (commit) begin
                wrSlot <= wrSlot + 1'b1;
            end
            if (releasePkt) begin
                rdSlot <= rdSlot + 1'b1;
            end
            occupancy <= occNext;
            ready <= (occNext != (slotIdxW + 1)'(slotCount));
        end
    end

    // Patched header lands after the raw one on a header-only packet
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrSlot][wrWord] <= wrData;
        end
        if (commit) begin
            mem[wrSlot][0] <= hdrData;
        end
    end

    assign rdData = mem[rdSlot][rdWord];
    assign pktAvail = (occupancy != '0);

endmodule

`default_nettype wire

// ==== pktSender.sv ====
/*
 * Output side of one port. Replays the oldest stored packet as a single
 * burst with valid, sop and eop, then frees its slot.
 */
`timescale 1ns/1ps
`default_nettype none

module pktSender (
    input  logic clk,
    input  logic nrst,
    input  logic pktAvail,
    input  switchPkg::pktWord rdData,
    output logic [switchPkg::wordIdxW-1:0] rdWord,
    output logic releasePkt,
    output switchPkg::pktWord data,
    output logic valid,
    output logic sop,
    output logic eop
);
    import switchPkg::*;

    senderState state;
    logic [wordIdxW-1:0] payloadLen;
    logic [wordIdxW-1:0] hdrLen;

    assign hdrLen = rdData.hdr.length[wordIdxW-1:0];
    assign releasePkt = (state == done);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state <= idle;
            rdWord <= '0;
            payloadLen <= '0;
            valid <= 1'b0;
            sop <= 1'b0;
            eop <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    valid <= 1'b0;
                    sop <= 1'b0;
                    eop <= 1'b0;
                    rdWord <= '0;
                    if (pktAvail) begin
                        state <= header;
                    end
                end
                header: begin
                    valid <= 1'b1;
                    sop <= 1'b1;
                    eop <= (hdrLen == '0);
                    payloadLen <= hdrLen;
                    if (hdrLen == '0) begin
                        state <= done;
                    end else begin
                        rdWord <= wordIdxW'(1);
                        state <= payload;
                    end
                end
                payload: begin
                    valid <= 1'b1;
                    sop <= 1'b0;
                    eop <= (rdWord == payloadLen);
                    if (rdWord == payloadLen) begin
                        state <= done;
                    end else begin
                        rdWord <= rdWord + 1'b1;
                    end
                end
                done: begin
                    // Gap cycle before the next burst
                    valid <= 1'b0;
                    sop <= 1'b0;
                    eop <= 1'b0;
                    rdWord <= '0;
                    state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == header || state == payload) begin
            data <= rdData;
        end
    end

endmodule

`default_nettype wire

// ==== switchTop.sv ====
/*
 * Two-port packet switch. The classifier steers each incoming packet into
 * the PortA or PortB buffer, and each port replays its packets on its own.
 */
`timescale 1ns/1ps
`default_nettype none

module switchTop (
    input  logic clk,
    input  logic nrst,
    input  logic sop,
    input  logic eop,
    input  logic inValid,
    input  switchPkg::pktWord portIn,
    output switchPkg::pktWord aData,
    output logic aValid,
    output logic aSop,
    output logic aEop,
    output logic aReady,
    output switchPkg::pktWord bData,
    output logic bValid,
    output logic bSop,
    output logic bEop,
    output logic bReady
);
    import switchPkg::*;

    logic wrEnA;
    logic wrEnB;
    logic commitA;
    logic commitB;
    logic [wordIdxW-1:0] wrWord;
    pktWord wrData;
    pktWord hdrData;

    logic [wordIdxW-1:0] rdWordA;
    logic [wordIdxW-1:0] rdWordB;
    pktWord rdDataA;
    pktWord rdDataB;
    logic pktAvailA;
    logic pktAvailB;
    logic releaseA;
    logic releaseB;

    pktClassifier uClassifier (
        .clk(clk), .nrst(nrst),
        .sop(sop), .eop(eop), .inValid(inValid), .portIn(portIn),
        .wrEnA(wrEnA), .wrEnB(wrEnB),
        .commitA(commitA), .commitB(commitB),
        .wrWord(wrWord), .wrData(wrData), .hdrData(hdrData)
    );

    // PortA path
    pktStore uStoreA (
        .clk(clk), .nrst(nrst),
        .wrEn(wrEnA), .wrWord(wrWord), .wrData(wrData),
        .commit(commitA), .hdrData(hdrData),
        .rdWord(rdWordA), .releasePkt(releaseA),
        .rdData(rdDataA), .pktAvail(pktAvailA), .ready(aReady)
    );

    pktSender uSenderA (
        .clk(clk), .nrst(nrst),
        .pktAvail(pktAvailA), .rdData(rdDataA),
        .rdWord(rdWordA), .releasePkt(releaseA),
        .data(aData), .valid(aValid), .sop(aSop), .eop(aEop)
    );

    // PortB path
    pktStore uStoreB (
        .clk(clk), .nrst(nrst),
        .wrEn(wrEnB), .wrWord(wrWord), .wrData(wrData),
        .commit(commitB), .hdrData(hdrData),
        .rdWord(rdWordB), .releasePkt(releaseB),
        .rdData(rdDataB), .pktAvail(pktAvailB), .ready(bReady)
    );

    pktSender uSenderB (
        .clk(clk), .nrst(nrst),
        .pktAvail(pktAvailB), .rdData(rdDataB),
        .rdWord(rdWordB), .releasePkt(releaseB),
        .data(bData), .valid(bValid), .sop(bSop), .eop(bEop)
    );

endmodule

`default_nettype wire

// ==== switchTb.sv ====
/*
 * Self-checking testbench for the two-port packet switch. Sends random
 * packets, predicts each port's output stream and compares it word by word.
 */
`timescale 1ns/1ps
`default_nettype none

module switchTb;
    import switchPkg::*;

    localparam int totalPackets = 27;
    localparam int timeoutNs = totalPackets * (wordsPerSlot + 8) * 40 * 4;

    logic clk = 1'b0;
    logic nrst;
    logic sop;
    logic eop;
    logic inValid;
    pktWord portIn;
    pktWord aData;
    pktWord bData;
    logic aValid;
    logic aSop;
    logic aEop;
    logic aReady;
    logic bValid;
    logic bSop;
    logic bEop;
    logic bReady;

    integer seed;
    int errors = 0;
    int testErrStart = 0;
    int pktCount = 0;
    int testCount = 0;
    pktWord payBuf [maxPayload];
    pktWord expA [$];
    pktWord expB [$];
    int lenA [$];
    int lenB [$];
    int wordPos [2] = '{0, 0};
    int pktLen [2] = '{0, 0};

    switchTop u_switchTop (.*);

    always #20 clk = ~clk;

    // Expected output word at position pos of the packet in payBuf
    function automatic pktWord expectPacket(input pktWord hdr, input int payloadCnt,
                                            input int pos);
        pktWord w;
        if (pos == 0) begin
            w = hdr;
            w.hdr.length = lenW'(payloadCnt);
        end else begin
            w = payBuf[pos - 1];
        end
        return w;
    endfunction

    function automatic logic [7:0] pickDestB();
        return 8'({$random(seed)} % 255 + 1);
    endfunction

    task automatic checkWord(input pktWord actual, input pktWord expected, input string what);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s got %h, expected %h", $time, what,
                     actual.raw, expected.raw);
            errors++;
        end
    endtask

    task automatic checkFlag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s got %b, expected %b", $time, what,
                     actual, expected);
            errors++;
        end
    endtask

    // One output cycle of a port against its expected stream
    task automatic checkPort(input int port, input pktWord d, input logic v,
                             input logic s, input logic e);
        pktWord expWord;
        string name;
        name = (port == 0) ? "port A" : "port B";
        if (!v) begin
            if (wordPos[port] != 0) begin
                $display("Error at %0d ns: %s dropped valid inside a packet", $time, name);
                errors++;
            end
            return;
        end
        if (wordPos[port] == 0) begin
            if (((port == 0) ? lenA.size() : lenB.size()) == 0) begin
                $display("Error at %0d ns: %s sent a packet nobody sent to it", $time, name);
                errors++;
                return;
            end
            pktLen[port] = (port == 0) ? lenA.pop_front() : lenB.pop_front();
        end
        expWord = (port == 0) ? expA.pop_front() : expB.pop_front();
        checkWord(d, expWord, {name, " data"});
        checkFlag(s, wordPos[port] == 0, {name, " sop"});
        checkFlag(e, wordPos[port] == pktLen[port] - 1, {name, " eop"});
        wordPos[port]++;
        if (wordPos[port] == pktLen[port]) begin
            wordPos[port] = 0;
            pktCount++;
        end
    endtask

    // Port monitors run mid-cycle where the registered outputs are stable
    always @(negedge clk) begin
        if (nrst) begin
            checkPort(0, aData, aValid, aSop, aEop);
        end
    end

    always @(negedge clk) begin
        if (nrst) begin
            checkPort(1, bData, bValid, bSop, bEop);
        end
    end

    // Incoming length byte is always wrong and has to be corrected
    task automatic sendPacket(input logic [7:0] dest, input int n, input int maxGap);
        pktWord hdr;
        int gap;
        int i;
        hdr.raw = $random(seed);
        hdr.hdr.dest = dest;
        hdr.hdr.length = lenW'(n) ^ 8'ha5;
        for (i = 0; i < n; i++) begin
            payBuf[i].raw = $random(seed);
        end
        while (((dest == portAId) ? aReady : bReady) !== 1'b1) begin
            @(posedge clk);
            #2;
        end
        for (i = 0; i <= n; i++) begin
            if (dest == portAId) begin
                expA.push_back(expectPacket(hdr, n, i));
            end else begin
                expB.push_back(expectPacket(hdr, n, i));
            end
        end
        if (dest == portAId) begin
            lenA.push_back(n + 1);
        end else begin
            lenB.push_back(n + 1);
        end
        for (i = 0; i <= n; i++) begin
            gap = (maxGap > 0 && i > 0) ? {$random(seed)} % maxGap + 1 : 0;
            repeat (gap) begin
                inValid = 1'b0;
                sop = 1'b0;
                eop = 1'b0;
                @(posedge clk);
                #2;
            end
            inValid = 1'b1;
            sop = (i == 0);
            eop = (i == n);
            if (i == 0) begin
                portIn = hdr;
            end else begin
                portIn = payBuf[i - 1];
            end
            @(posedge clk);
            #2;
        end
        inValid = 1'b0;
        sop = 1'b0;
        eop = 1'b0;
    endtask

    task automatic waitDrain();
        while (expA.size() != 0 || expB.size() != 0) begin
            @(posedge clk);
            #2;
        end
        repeat (4) @(posedge clk);
        #2;
    endtask

    task automatic finishTest(input string name);
        testCount++;
        $display("test %0d %s: done, %0d errors", testCount, name, errors - testErrStart);
        testErrStart = errors;
    endtask

    initial begin
        seed = 32'hbb16_a7d8;
        nrst = 1'b0;
        sop = 1'b0;
        eop = 1'b0;
        inValid = 1'b0;
        portIn = '0;

        repeat (8) begin
            @(posedge clk);
            #2;
            checkFlag(aValid, 1'b0, "aValid in reset");
            checkFlag(bValid, 1'b0, "bValid in reset");
            checkFlag(aSop | aEop, 1'b0, "port A sop/eop in reset");
            checkFlag(bSop | bEop, 1'b0, "port B sop/eop in reset");
            checkFlag(aReady, 1'b0, "aReady in reset");
            checkFlag(bReady, 1'b0, "bReady in reset");
        end
        nrst = 1'b1;
        @(posedge clk);
        #2;
        checkFlag(aReady, 1'b1, "aReady after reset");
        checkFlag(bReady, 1'b1, "bReady after reset");
        finishTest("reset");

        sendPacket(portAId, 3, 0);
        sendPacket(pickDestB(), 2, 0);
        sendPacket(portAId, 0, 0);
        sendPacket(8'hff, 5, 0);
        sendPacket(pickDestB(), 1, 0);
        sendPacket(portAId, 7, 0);
        waitDrain();
        finishTest("routing");

        repeat (8) begin
            sendPacket(($random(seed) & 1) ? portAId : pickDestB(),
                       {$random(seed)} % (maxPayload + 1), 0);
        end
        waitDrain();
        finishTest("length rewrite and payload");

        sendPacket(portAId, 0, 0);
        sendPacket(pickDestB(), 0, 0);
        sendPacket(pickDestB(), 0, 0);
        sendPacket(portAId, 0, 0);
        waitDrain();
        finishTest("header only");

        // Long first packet keeps sender B busy while the store fills
        sendPacket(pickDestB(), maxPayload, 0);
        repeat (3) sendPacket(pickDestB(), {$random(seed)} % 3, 0);
        checkFlag(bReady, 1'b0, "bReady with four packets stored");
        sendPacket(pickDestB(), 4, 0);
        waitDrain();
        finishTest("ordering and capacity");

        // At least one payload word, so every packet has idle input cycles
        repeat (4) begin
            sendPacket(($random(seed) & 1) ? portAId : pickDestB(),
                       {$random(seed)} % maxPayload + 1, 2);
        end
        waitDrain();
        finishTest("input gaps");

        $display("%0d tests, %0d packets checked, %0d errors", testCount, pktCount, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(timeoutNs);
        $display("Timeout at %0d ns: %0d packets never arrived", $time,
                 lenA.size() + lenB.size());
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
switchPkg.sv
pktClassifier.sv
pktStore.sv
pktSender.sv
switchTop.sv
switchTb.sv
